// File: design/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // 8N1 character format on both serial lines
    localparam int DATA_BITS = 8;   // Payload bits per character
    localparam int WORD_BYTES = 4;  // Characters per 32-bit debug word

    // Line levels
    localparam logic START_BIT = 1'b0; // Start bit pulls the line low
    localparam logic STOP_BIT = 1'b1;  // Stop bit and idle level are high

endpackage

`default_nettype wire

// File: design/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

    // Host command opcodes in bits 31..24 of a header word
    typedef enum logic [7:0] {
        OP_WRITE = 8'h01, // Next word is data for the header address
        OP_READ = 8'h02,  // Reply with the stored word
        OP_PING = 8'h03   // Reply with PING_REPLY
    } dbg_op_e;

    // A received word is decoded as a command header or taken as raw data
    typedef union packed {
        struct packed {
            dbg_op_e opcode;   // Bits 31..24
            logic [14:0] rsvd; // Not decoded
            logic [8:0] addr;  // Word address, low bits used by the memory
        } hdr;
        logic [31:0] raw;      // Write payload
    } dbg_word_u;

    localparam logic [31:0] PING_REPLY = 32'h5AFE_0001;     // Liveness answer
    localparam logic [31:0] ERR_REPLY_BASE = 32'hBAD0_0000; // Bad opcode lands in bits 7..0

endpackage

`default_nettype wire

// File: design/uart_rx.sv
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 434
)(
    input wire i_clk,
    input wire i_rst,
    input wire i_rx,                                  // Asynchronous serial line
    output logic o_done,                              // One cycle per good frame
    output logic [uart_pkg::DATA_BITS-1:0] o_byte     // Valid with o_done
);

    import uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(DATA_BITS);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);      // Full bit time
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1); // Half bit time
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(DATA_BITS - 1);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA = 2'd2;
    localparam logic [1:0] S_STOP = 2'd3;

    logic rx_meta;             // First synchronizer stage
    logic rx_sync;             // Second synchronizer stage
    logic rx_prev;             // Delayed copy for edge detect
    logic [1:0] state;
    logic [CNT_W-1:0] cnt;     // Clocks within the current bit
    logic [IDX_W-1:0] bit_idx; // Data bit being sampled

    always_ff @(posedge i_clk) begin
        o_done <= 1'b0; // Default strobe low
        if (i_rst) begin
            rx_meta <= STOP_BIT;
            rx_sync <= STOP_BIT;
            rx_prev <= STOP_BIT;
            state <= S_IDLE;
            cnt <= '0;
            bit_idx <= '0;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    if (rx_prev == STOP_BIT && rx_sync == START_BIT) begin // Falling edge
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (cnt == HALF_LAST) begin // Middle of start bit
                        cnt <= '0;
                        bit_idx <= '0;
                        state <= (rx_sync == START_BIT) ? S_DATA : S_IDLE; // Reject glitches
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (cnt == BIT_LAST) begin // Middle of a data bit
                        cnt <= '0;
                        o_byte <= {rx_sync, o_byte[DATA_BITS-1:1]}; // LSB arrives first
                        if (bit_idx == IDX_LAST) begin
                            state <= S_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == BIT_LAST) begin // Middle of stop bit
                        state <= S_IDLE;
                        o_done <= (rx_sync == STOP_BIT); // Framing error drops the byte
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/debug_unit.sv
`default_nettype none

module debug_unit #(
    parameter int PROG_ADDR_W = 6
)(
    input wire i_clk,
    input wire i_rst,
    input wire i_rx_done,                               // Byte strobe from the receiver
    input wire [uart_pkg::DATA_BITS-1:0] i_rx_byte,
    input wire [31:0] i_mem_rdata,                      // Valid one cycle after o_mem_re
    output logic o_mem_we,
    output logic o_mem_re,
    output logic [PROG_ADDR_W-1:0] o_mem_addr,
    output logic [31:0] o_mem_wdata,
    output logic o_fifo_wr,                             // Reply strobe
    output logic [31:0] o_fifo_wdata
);

    import uart_pkg::*;
    import dbg_pkg::*;

    localparam int BCNT_W = $clog2(WORD_BYTES);
    localparam logic [BCNT_W-1:0] BYTE_LAST = BCNT_W'(WORD_BYTES - 1);

    localparam logic [1:0] S_HDR = 2'd0;   // Expecting a command header
    localparam logic [1:0] S_WDATA = 2'd1; // Expecting write payload
    localparam logic [1:0] S_RWAIT = 2'd2; // Memory read in flight

    dbg_word_u cmd;                   // Assembled word
    logic [BCNT_W-1:0] byte_cnt;      // Bytes collected so far
    logic word_rdy;                   // Full word present in cmd
    logic [1:0] state;
    logic [PROG_ADDR_W-1:0] wr_addr;  // Target of a pending write

    // Word assembly, the newest byte enters at the top
    always_ff @(posedge i_clk) begin
        if (i_rx_done) begin
            cmd.raw <= {i_rx_byte, cmd.raw[31:DATA_BITS]};
        end
    end

    // Memory strobes act in the cycle the word becomes ready
    assign o_mem_we = word_rdy && (state == S_WDATA);
    assign o_mem_re = word_rdy && (state == S_HDR) && (cmd.hdr.opcode == OP_READ);
    assign o_mem_addr = (state == S_WDATA) ? wr_addr : cmd.hdr.addr[PROG_ADDR_W-1:0]; // Wraps
    assign o_mem_wdata = cmd.raw;

    always_ff @(posedge i_clk) begin
        o_fifo_wr <= 1'b0; // Default strobe low
        if (i_rst) begin
            byte_cnt <= '0;
            word_rdy <= 1'b0;
            state <= S_HDR;
        end else begin
            word_rdy <= i_rx_done && (byte_cnt == BYTE_LAST);
            if (i_rx_done) begin
                byte_cnt <= (byte_cnt == BYTE_LAST) ? '0 : byte_cnt + 1'b1;
            end
            case (state)
                S_HDR: begin
                    if (word_rdy) begin
                        case (cmd.hdr.opcode)
                            OP_WRITE: begin
                                wr_addr <= cmd.hdr.addr[PROG_ADDR_W-1:0]; // Hold for data word
                                state <= S_WDATA;
                            end
                            OP_READ: state <= S_RWAIT; // o_mem_re fires now
                            OP_PING: begin
                                o_fifo_wr <= 1'b1;
                                o_fifo_wdata <= PING_REPLY;
                            end
                            default: begin
                                o_fifo_wr <= 1'b1;
                                o_fifo_wdata <= ERR_REPLY_BASE + 32'(cmd.hdr.opcode); // Echo bad op
                            end
                        endcase
                    end
                end
                S_WDATA: begin
                    if (word_rdy) begin // Data written through o_mem_we this cycle
                        state <= S_HDR;
                    end
                end
                S_RWAIT: begin
                    o_fifo_wr <= 1'b1; // Read data is valid now
                    o_fifo_wdata <= i_mem_rdata;
                    state <= S_HDR;
                end
                default: state <= S_HDR;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/prog_mem.sv
`default_nettype none

module prog_mem #(
    parameter int PROG_ADDR_W = 6
)(
    input wire i_clk,
    input wire i_we,                        // Write strobe
    input wire i_re,                        // Read strobe
    input wire [PROG_ADDR_W-1:0] i_addr,
    input wire [31:0] i_wdata,
    output logic [31:0] o_rdata             // Registered, one cycle after i_re
);

    logic [31:0] mem [2**PROG_ADDR_W]; // Instruction store

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        if (i_re) begin
            o_rdata <= mem[i_addr];
        end
    end

endmodule

`default_nettype wire

// File: design/tx_serializer.sv
`default_nettype none

module tx_serializer #(
    parameter int FIFO_ADDR_W = 3
)(
    input wire i_clk,
    input wire i_rst,
    input wire i_wr,                                     // Push a reply word
    input wire [31:0] i_wdata,
    input wire i_tx_done,                                // Transmitter finished a byte
    output logic o_tx_start,
    output logic [uart_pkg::DATA_BITS-1:0] o_tx_byte,
    output logic o_full
);

    import uart_pkg::*;

    localparam int IDX_W = $clog2(WORD_BYTES);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(WORD_BYTES - 1);

    logic [31:0] fifo_mem [2**FIFO_ADDR_W];
    logic [FIFO_ADDR_W:0] wr_ptr;  // Extra MSB tells full from empty
    logic [FIFO_ADDR_W:0] rd_ptr;
    logic empty;
    logic push;
    logic pop;
    logic next_byte;               // Advance to the following byte of the word
    logic busy;                    // A word is being walked out
    logic [IDX_W-1:0] byte_idx;
    logic [31:0] hold;             // Remaining bytes, current one at the bottom

    assign empty = (wr_ptr == rd_ptr);
    assign o_full = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) &&
                    (wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);
    assign push = i_wr && !o_full;        // Drop when full
    assign pop = !busy && !empty;
    assign next_byte = busy && i_tx_done;
    assign o_tx_byte = hold[DATA_BITS-1:0];

    always_ff @(posedge i_clk) begin
        if (push) begin
            fifo_mem[wr_ptr[FIFO_ADDR_W-1:0]] <= i_wdata;
        end
        if (pop) begin
            hold <= fifo_mem[rd_ptr[FIFO_ADDR_W-1:0]];
        end else if (next_byte) begin
            hold <= hold >> DATA_BITS; // Least significant byte leaves first
        end
    end

    always_ff @(posedge i_clk) begin
        o_tx_start <= 1'b0; // Default strobe low
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            busy <= 1'b0;
            byte_idx <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                busy <= 1'b1;
                byte_idx <= '0;
                o_tx_start <= 1'b1; // Byte 0 goes out with the fresh word
            end else if (next_byte) begin
                if (byte_idx == IDX_LAST) begin
                    busy <= 1'b0; // Word done
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                    o_tx_start <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/uart_tx.sv
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 434
)(
    input wire i_clk,
    input wire i_rst,
    input wire i_start,                              // Accepted only while idle
    input wire [uart_pkg::DATA_BITS-1:0] i_byte,
    output logic o_tx,                               // Serial line, idle high
    output logic o_done                              // One cycle after the stop bit
);

    import uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(DATA_BITS);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(DATA_BITS - 1);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA = 2'd2;
    localparam logic [1:0] S_STOP = 2'd3;

    logic [1:0] state;
    logic [CNT_W-1:0] cnt;            // Clocks within the current bit
    logic [IDX_W-1:0] bit_idx;        // Data bit on the line
    logic [DATA_BITS-1:0] shift;      // Bits still to send

    always_ff @(posedge i_clk) begin
        o_done <= 1'b0; // Default strobe low
        if (i_rst) begin
            state <= S_IDLE;
            o_tx <= STOP_BIT;
            cnt <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    if (i_start) begin
                        shift <= i_byte;
                        o_tx <= START_BIT;
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (cnt == BIT_LAST) begin
                        cnt <= '0;
                        bit_idx <= '0;
                        o_tx <= shift[0]; // LSB first
                        shift <= shift >> 1;
                        state <= S_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (cnt == BIT_LAST) begin
                        cnt <= '0;
                        if (bit_idx == IDX_LAST) begin
                            o_tx <= STOP_BIT;
                            state <= S_STOP;
                        end else begin
                            o_tx <= shift[0];
                            shift <= shift >> 1;
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == BIT_LAST) begin // Stop bit complete
                        o_done <= 1'b1;
                        state <= S_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/debug_top.sv
`default_nettype none

module debug_top #(
    parameter int CLKS_PER_BIT = 434,  // Clocks per serial bit
    parameter int PROG_ADDR_W = 6,     // 64-word program memory
    parameter int FIFO_ADDR_W = 3      // 8-word reply FIFO
)(
    input wire i_clk,
    input wire i_rst,
    input wire i_rx,    // Host to target serial line
    output logic o_tx   // Target to host serial line
);

    import uart_pkg::*;

    // Receive path
    logic rx_done;
    logic [DATA_BITS-1:0] rx_byte;

    // Debug unit to program memory
    logic mem_we;
    logic mem_re;
    logic [PROG_ADDR_W-1:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;

    // Reply path
    logic fifo_wr;
    logic [31:0] fifo_wdata;
    logic fifo_full;             // Observed by the bound assertions
    logic tx_start;
    logic [DATA_BITS-1:0] tx_byte;
    logic tx_done;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_rx (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_rx(i_rx),
        .o_done(rx_done),
        .o_byte(rx_byte)
    );

    debug_unit #(
        .PROG_ADDR_W(PROG_ADDR_W)
    ) u_debug_unit (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_rx_done(rx_done),
        .i_rx_byte(rx_byte),
        .i_mem_rdata(mem_rdata),
        .o_mem_we(mem_we),
        .o_mem_re(mem_re),
        .o_mem_addr(mem_addr),
        .o_mem_wdata(mem_wdata),
        .o_fifo_wr(fifo_wr),
        .o_fifo_wdata(fifo_wdata)
    );

    prog_mem #(
        .PROG_ADDR_W(PROG_ADDR_W)
    ) u_prog_mem (
        .i_clk(i_clk),
        .i_we(mem_we),
        .i_re(mem_re),
        .i_addr(mem_addr),
        .i_wdata(mem_wdata),
        .o_rdata(mem_rdata)
    );

    tx_serializer #(
        .FIFO_ADDR_W(FIFO_ADDR_W)
    ) u_tx_serializer (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_wr(fifo_wr),
        .i_wdata(fifo_wdata),
        .i_tx_done(tx_done),
        .o_tx_start(tx_start),
        .o_tx_byte(tx_byte),
        .o_full(fifo_full)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_tx (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_start(tx_start),
        .i_byte(tx_byte),
        .o_tx(o_tx),
        .o_done(tx_done)
    );

endmodule

`default_nettype wire

// File: test/debug_properties.sv
`default_nettype none

module debug_properties (
    input wire i_clk,
    input wire i_rst,
    input wire i_tx,
    input wire i_fifo_wr,
    input wire i_fifo_full,
    input wire i_mem_we,
    input wire i_mem_re
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0; // Assertion failures so far

    // Line idles through reset and one cycle past it
    tx_idle_in_reset: assert property (@(posedge i_clk) i_rst |=> i_tx)
        else begin
            $error("o_tx was low during or just after reset");
            fail_cnt++;
        end

    no_write_when_full: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_fifo_wr && i_fifo_full))
        else begin
            $error("Reply word written while the reply FIFO was full");
            fail_cnt++;
        end

    single_mem_access: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_mem_we && i_mem_re))
        else begin
            $error("Program memory written and read in the same cycle");
            fail_cnt++;
        end

endmodule

bind debug_top debug_properties props_i (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_tx(o_tx),
    .i_fifo_wr(fifo_wr),
    .i_fifo_full(fifo_full),
    .i_mem_we(mem_we),
    .i_mem_re(mem_re)
);

`default_nettype wire

// File: test/debug_checker.sv
`default_nettype none

module debug_checker #(
    parameter int CLKS_PER_BIT = 16
)(
    input wire i_clk,
    input wire i_tx,                 // DUT serial output
    input wire i_exp_push,           // One expected reply per pulse
    input wire [7:0] i_exp_tag,
    input wire [31:0] i_exp_word,
    input wire i_cmds_done,          // Replies may be waited for now
    output logic o_idle,             // Nothing expected and no word in progress
    output int o_pass_cnt,
    output int o_fail_cnt,
    output int o_err_cnt
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int START_TIMEOUT = 2000; // Cycles to wait for a start bit

    logic [31:0] exp_q [$];          // Expected reply words in order
    logic [7:0] tag_q [$];           // Test tag of each expected word
    int byte_idx = 0;                // Bytes of the current word received
    logic test_bad = 1'b0;
    logic [7:0] cur_tag = '0;

    function automatic string test_name(input logic [7:0] tag);
        case (tag)
            8'h01: return "write_then_read";
            8'h02: return "queued_reads";
            8'h03: return "ping";
            8'h04: return "bad_opcode";
            8'h05: return "address_wrap";
            8'h06: return "overwrite";
            default: return $sformatf("tag_%0h", tag);
        endcase
    endfunction

    always @(posedge i_clk) begin
        if (i_exp_push) begin
            exp_q.push_back(i_exp_word);
            tag_q.push_back(i_exp_tag);
        end
    end

    always @(negedge i_clk) begin
        o_idle = (exp_q.size() == 0) && (byte_idx == 0);
    end

    task automatic close_test();
        if (test_bad) begin
            o_fail_cnt++;
            $display("FAIL %s", test_name(cur_tag));
        end else begin
            o_pass_cnt++;
            $display("PASS %s", test_name(cur_tag));
        end
        test_bad = 1'b0;
    endtask

    // Counts only while a reply is due, so commands still in flight never expire it
    task automatic wait_start(output logic found);
        int waited;
        waited = 0;
        found = 1'b1;
        while (i_tx !== 1'b0 && found) begin
            @(negedge i_clk);
            if ((exp_q.size() != 0 && i_cmds_done) || byte_idx != 0) begin
                waited++;
            end
            if (waited >= START_TIMEOUT) begin
                found = 1'b0;
            end
        end
    endtask

    // Entered half a cycle after the falling start edge, samples each bit mid-way
    task automatic read_byte(output logic [7:0] data, output logic frame_ok);
        int i;
        repeat (CLKS_PER_BIT / 2) @(negedge i_clk);
        frame_ok = (i_tx === 1'b0); // Start bit still low
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge i_clk);
            data[i] = i_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge i_clk);
        frame_ok = frame_ok && (i_tx === 1'b1); // Stop bit
    endtask

    task automatic check_word(input logic [31:0] word);
        logic [31:0] exp;
        if (exp_q.size() == 0) begin
            $display("Unexpected reply word %08h on o_tx", word);
            o_err_cnt++;
        end else begin
            cur_tag = tag_q.pop_front();
            exp = exp_q.pop_front();
            if (word !== exp) begin
                $display("ERROR %s: expected %08h, actual %08h", test_name(cur_tag), exp, word);
                test_bad = 1'b1;
            end
            if (exp_q.size() == 0) begin
                close_test(); // Last reply of the test
            end
        end
    endtask

    initial begin
        logic [7:0] data;
        logic frame_ok;
        logic found;
        logic [31:0] word;
        int waited;
        o_pass_cnt = 0;
        o_fail_cnt = 0;
        o_err_cnt = 0;
        word = '0;
        waited = 0;
        while (i_tx !== 1'b1 && waited < START_TIMEOUT) begin // Line idles high once reset acts
            @(negedge i_clk);
            waited++;
        end
        if (i_tx !== 1'b1) begin
            $display("o_tx never went to the idle level after reset");
            o_err_cnt++;
        end
        forever begin
            wait_start(found);
            if (!found && exp_q.size() == 0) begin
                $display("Reply word cut off on o_tx after %0d bytes", byte_idx);
                o_err_cnt++;
                byte_idx = 0;
            end else if (!found) begin
                $display("Test %s: no reply received", test_name(tag_q[0]));
                cur_tag = tag_q[0];
                test_bad = 1'b1;
                exp_q.delete(); // Remaining replies of this test are lost
                tag_q.delete();
                byte_idx = 0;
                close_test();
            end else begin
                read_byte(data, frame_ok);
                if (!frame_ok) begin
                    $display("Bad start or stop bit on o_tx");
                    o_err_cnt++;
                end
                word = {data, word[31:8]}; // Bytes arrive LSB first
                if (byte_idx == 3) begin
                    byte_idx = 0;
                    check_word(word);
                end else begin
                    byte_idx++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_debug_top.sv
`default_nettype none

module tb_debug_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLKS_PER_BIT = 16;     // Short bit time for simulation
    localparam int DATA_DEPTH = 256;      // Words of test data
    localparam int DONE_TIMEOUT = 20000;  // Cycles allowed for a test's replies

    logic clk;
    logic rst;
    logic rx;                             // Host to DUT serial line
    logic tx;                             // DUT to host serial line
    logic exp_push;                       // Hands one expected reply to the checker
    logic [7:0] exp_tag;
    logic [31:0] exp_word;
    logic cmds_done;                      // Last command byte of the test is sent
    logic chk_idle;
    int pass_cnt;
    int fail_cnt;
    int err_cnt;
    logic [31:0] tdata [DATA_DEPTH];      // Loaded from the test data file

    debug_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) dut_i (
        .i_clk(clk),
        .i_rst(rst),
        .i_rx(rx),
        .o_tx(tx)
    );

    debug_checker #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) checker_i (
        .i_clk(clk),
        .i_tx(tx),
        .i_exp_push(exp_push),
        .i_exp_tag(exp_tag),
        .i_exp_word(exp_word),
        .i_cmds_done(cmds_done),
        .o_idle(chk_idle),
        .o_pass_cnt(pass_cnt),
        .o_fail_cnt(fail_cnt),
        .o_err_cnt(err_cnt)
    );

    always #5 clk = ~clk; // 10 ns period

    // Holds the line at one level for a bit time, ends 1 ns after a rising edge
    task automatic hold_line(input logic level);
        rx = level;
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] data);
        int i;
        hold_line(1'b0); // Start bit
        for (i = 0; i < 8; i++) begin
            hold_line(data[i]); // LSB first
        end
        hold_line(1'b1); // Stop bit
    endtask

    task automatic send_word(input logic [31:0] word);
        int k;
        int g;
        int gap;
        for (k = 0; k < 4; k++) begin
            gap = $urandom_range(20, 0); // Idle bit times before the byte
            for (g = 0; g < gap; g++) begin
                hold_line(1'b1);
            end
            send_byte(word[8*k +: 8]); // Least significant byte first
        end
    endtask

    task automatic push_expected(input logic [7:0] tag, input logic [31:0] word);
        exp_push = 1'b1;
        exp_tag = tag;
        exp_word = word;
        @(posedge clk);
        #1;
        exp_push = 1'b0;
    endtask

    // Waits until the checker has consumed every reply of the test
    task automatic wait_replies(output logic late);
        int waited;
        waited = 0;
        while (!chk_idle && waited < DONE_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        late = !chk_idle;
        #1;
    endtask

    initial begin
        int p;
        int i;
        int ncmd;
        int nexp;
        int ntests;
        int assert_fails;
        logic [7:0] tag;
        logic timed_out;
        void'($urandom(32'h9a01));
        clk = 1'b0;
        rst = 1'b1;
        rx = 1'b1;          // Line idles high
        exp_push = 1'b0;
        exp_tag = '0;
        exp_word = '0;
        cmds_done = 1'b0;
        $readmemh("test/testdata.txt", tdata);
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        p = 0;
        ntests = 0;
        timed_out = 1'b0;
        while (p < DATA_DEPTH && tdata[p] != 32'd0 && !timed_out) begin
            tag = tdata[p][7:0];
            ncmd = int'(tdata[p+1]);
            nexp = int'(tdata[p+2+ncmd]);
            for (i = 0; i < nexp; i++) begin
                push_expected(tag, tdata[p+3+ncmd+i]); // Queued before the replies can start
            end
            for (i = 0; i < ncmd; i++) begin
                send_word(tdata[p+2+i]);
            end
            cmds_done = 1'b1;
            wait_replies(timed_out);
            if (timed_out) begin
                $display("Replies of test %0d did not finish within %0d cycles", tag, DONE_TIMEOUT);
            end
            cmds_done = 1'b0;
            p += 3 + ncmd + nexp;
            ntests++;
        end
        assert_fails = dut_i.props_i.fail_cnt;
        $display("Tests: %0d, passed: %0d, failed: %0d, other errors: %0d, assertion failures: %0d",
                 ntests, pass_cnt, fail_cnt, err_cnt, assert_fails);
        if (!timed_out && fail_cnt == 0 && err_cnt == 0 && assert_fails == 0 &&
            pass_cnt == ntests) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/testdata.txt
// One test per line: tag, command count, command words, reply count, reply words
// Tags select the test name in the checker, a tag of 0 ends the list
1 3 01000010 DEADBEEF 02000010 1 DEADBEEF
2 7 01000001 11111111 01000002 22222222 02000010 02000001 02000002 3 DEADBEEF 11111111 22222222
3 1 03000000 1 5AFE0001
4 1 7E000000 1 BAD0007E
5 3 01000045 CAFEF00D 02000005 1 CAFEF00D
6 5 01000020 12345678 01000020 9ABCDEF0 02000020 1 9ABCDEF0
0

// File: build.f
design/uart_pkg.sv
design/dbg_pkg.sv
design/uart_rx.sv
design/debug_unit.sv
design/prog_mem.sv
design/tx_serializer.sv
design/uart_tx.sv
design/debug_top.sv
test/debug_properties.sv
test/debug_checker.sv
test/tb_debug_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_debug_top -o sim_tb
output=$(./obj_dir/sim_tb +verilator+error+limit+100) || true
echo "$output"
if grep -q "All tests passed" <<< "$output"; then
    exit 0
fi
exit 1
